//--- design/axil_readout.sv
`timescale 1ns/1ps
`default_nettype none

module axil_readout (
   input  logic                                clk,
   input  logic                                rst_n,
   input  capture_pkg::axil_req_t              axil_req,
   output capture_pkg::axil_rsp_t              axil_rsp,
   output logic                                capture_en,
   output capture_pkg::ram_req_t               rd_req,     // Buffer read towards the arbiter
   input  logic                                rd_grant,
   input  logic [capture_pkg::axil_data_w-1:0] rd_data,
   input  logic                                rd_valid,
   input  logic [capture_pkg::frame_w-1:0]     frame_count,
   input  logic [capture_pkg::buf_aw-1:0]      wptr
);

   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   capture_pkg::axil_state_e               state;
   logic                                   w_hs;       // Address and data taken together
   logic                                   ar_hs;
   logic                                   rd_pend;    // Buffer request not yet granted
   logic                                   in_buf;     // Read hits the buffer window
   logic                                   ar_err;
   logic [capture_pkg::axil_addr_w-1:0]    buf_off;
   logic [capture_pkg::axil_data_w-1:0]    reg_rdata;
   logic [capture_pkg::axil_data_w-1:0]    rdata_q;
   logic [capture_pkg::buf_aw-1:0]         rd_idx;
   logic [1:0]                             bresp_q;
   logic [1:0]                             rresp_q;

   // Reads take priority when both arrive in idle
   assign ar_hs = (state == capture_pkg::st_idle) && axil_req.arvalid;
   assign w_hs  = (state == capture_pkg::st_idle) && axil_req.awvalid && axil_req.wvalid
                  && !axil_req.arvalid;

   assign buf_off = axil_req.araddr - capture_pkg::buf_base; // Wraps high below the window
   assign in_buf  = buf_off < (4 << capture_pkg::buf_aw);

   // Register read decode
   always_comb begin
      reg_rdata = '0;
      ar_err    = 1'b0;
      if (axil_req.araddr == capture_pkg::reg_ctrl) begin
         reg_rdata[0] = capture_en;
      end else if (axil_req.araddr == capture_pkg::reg_frames) begin
         reg_rdata[capture_pkg::frame_w-1:0] = frame_count;
      end else if (axil_req.araddr == capture_pkg::reg_wptr) begin
         reg_rdata[capture_pkg::buf_aw-1:0] = wptr;
      end else if (!in_buf) begin
         ar_err = 1'b1;                               // Unmapped, data stays zero
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= capture_pkg::st_idle;
         capture_en <= 1'b0;
         rd_pend    <= 1'b0;
         bresp_q    <= resp_okay;
         rresp_q    <= resp_okay;
      end else begin
         case (state)
            capture_pkg::st_idle: begin
               if (ar_hs) begin
                  rresp_q <= ar_err ? resp_slverr : resp_okay;
                  rd_pend <= in_buf;
                  state   <= in_buf ? capture_pkg::st_rwait : capture_pkg::st_rdata;
               end else if (w_hs) begin
                  if (axil_req.awaddr == capture_pkg::reg_ctrl) begin
                     if (axil_req.wstrb[0]) begin
                        capture_en <= axil_req.wdata[0];
                     end
                     bresp_q <= resp_okay;
                  end else begin
                     bresp_q <= resp_slverr;        // Only ctrl is writable
                  end
                  state <= capture_pkg::st_wresp;
               end
            end
            capture_pkg::st_wresp: begin
               if (axil_req.bready) begin
                  state <= capture_pkg::st_idle;
               end
            end
            capture_pkg::st_rwait: begin
               if (rd_grant) begin
                  rd_pend <= 1'b0;                    // Drop request once granted
               end
               if (rd_valid) begin
                  state <= capture_pkg::st_rdata;
               end
            end
            capture_pkg::st_rdata: begin
               if (axil_req.rready) begin
                  state <= capture_pkg::st_idle;
               end
            end
            default: state <= capture_pkg::st_idle;
         endcase
      end
   end

   // Read payload, loaded at address accept or from the buffer
   always_ff @(posedge clk) begin
      if (ar_hs) begin
         rd_idx  <= buf_off[capture_pkg::buf_aw+1:2];
         rdata_q <= reg_rdata;
      end else if (state == capture_pkg::st_rwait && rd_valid) begin
         rdata_q <= rd_data;
      end
   end

   always_comb begin
      rd_req      = '0;
      rd_req.en   = (state == capture_pkg::st_rwait) && rd_pend;
      rd_req.addr = rd_idx;                           // we stays low
   end

   always_comb begin
      axil_rsp         = '0;
      axil_rsp.awready = w_hs;
      axil_rsp.wready  = w_hs;
      axil_rsp.bvalid  = (state == capture_pkg::st_wresp);
      axil_rsp.bresp   = bresp_q;
      axil_rsp.arready = (state == capture_pkg::st_idle);
      axil_rsp.rvalid  = (state == capture_pkg::st_rdata);
      axil_rsp.rdata   = rdata_q;
      axil_rsp.rresp   = rresp_q;
   end

   // Held response must not change under back-pressure
   a_rvalid_hold : assert property (@(posedge clk) disable iff (!rst_n)
      axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata));

endmodule

`default_nettype wire

//--- design/buffer_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module buffer_arbiter (
   input  logic                                clk,
   input  logic                                rst_n,
   input  capture_pkg::ram_req_t               wr_req,    // Stream writer with fixed priority
   input  capture_pkg::ram_req_t               rd_req,    // Host reader
   input  logic [capture_pkg::axil_data_w-1:0] ram_rdata,
   output capture_pkg::ram_req_t               ram_req,
   output logic                                rd_grant,
   output logic [capture_pkg::axil_data_w-1:0] rd_data,
   output logic                                rd_valid
);

   capture_pkg::arb_owner_e owner;                    // Who used the port last cycle

   assign rd_grant = rd_req.en && !wr_req.en;         // Reader only gets idle cycles

   always_comb begin
      if (wr_req.en) begin
         ram_req = wr_req;
      end else begin
         ram_req    = rd_req;
         ram_req.we = 1'b0;                           // Reader never writes
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         owner <= capture_pkg::own_none;
      end else if (wr_req.en) begin
         owner <= capture_pkg::own_writer;
      end else if (rd_grant) begin
         owner <= capture_pkg::own_reader;
      end else begin
         owner <= capture_pkg::own_none;
      end
   end

   // RAM output belongs to the reader one cycle after its grant
   assign rd_valid = (owner == capture_pkg::own_reader);
   assign rd_data  = rd_valid ? ram_rdata : '0;

   // A blocked reader keeps its request and address until granted
   a_rd_hold : assert property (@(posedge clk) disable iff (!rst_n)
      rd_req.en && !rd_grant |=> rd_req.en && $stable(rd_req.addr));

   // Writer requests always carry a write
   a_wr_we : assert property (@(posedge clk) disable iff (!rst_n)
      wr_req.en |-> wr_req.we);

endmodule

`default_nettype wire

//--- design/capture_pkg.sv
`default_nettype none

package capture_pkg;

   localparam int axil_data_w = 32;                  // AXI4-Lite data width
   localparam int axil_addr_w = 12;                  // AXI4-Lite byte address width
   localparam int buf_aw      = 8;                   // 256 buffer words
   localparam int frame_w     = 16;                  // Completed-frame counter width

   localparam logic [axil_addr_w-1:0] reg_ctrl   = 12'h000; // Bit 0 capture enable
   localparam logic [axil_addr_w-1:0] reg_frames = 12'h004; // Completed frames, read only
   localparam logic [axil_addr_w-1:0] reg_wptr   = 12'h008; // Write pointer, read only
   localparam logic [axil_addr_w-1:0] buf_base   = 12'h400; // Buffer window, word i at +4*i

   typedef struct packed {
      logic                     awvalid;
      logic [axil_addr_w-1:0]   awaddr;
      logic                     wvalid;
      logic [axil_data_w-1:0]   wdata;
      logic [axil_data_w/8-1:0] wstrb;
      logic                     bready;
      logic                     arvalid;
      logic [axil_addr_w-1:0]   araddr;
      logic                     rready;
   } axil_req_t;                                     // Master to slave

   typedef struct packed {
      logic                     awready;
      logic                     wready;
      logic                     bvalid;
      logic [1:0]               bresp;
      logic                     arready;
      logic                     rvalid;
      logic [axil_data_w-1:0]   rdata;
      logic [1:0]               rresp;
   } axil_rsp_t;                                     // Slave to master

   typedef struct packed {
      logic                     en;
      logic                     we;
      logic [buf_aw-1:0]        addr;
      logic [axil_data_w-1:0]   wdata;
   } ram_req_t;                                      // One buffer port access

   typedef enum logic [1:0] {own_none, own_writer, own_reader} arb_owner_e;

   typedef enum logic [1:0] {st_idle, st_wresp, st_rwait, st_rdata} axil_state_e;

endpackage

`default_nettype wire

//--- design/capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module capture_top #(
   parameter int n_chan = 8,                         // Channels per frame
   parameter int dw     = 16,                        // Channel word width
   parameter int l_to_r = 1                          // 1 stores CH0 first
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   sample_in,
   input  logic [n_chan*dw-1:0]   data_in,
   input  capture_pkg::axil_req_t axil_req,
   output capture_pkg::axil_rsp_t axil_rsp
);

   logic [dw-1:0]                       stream;
   logic                                gate;
   logic                                capture_en;
   logic [capture_pkg::frame_w-1:0]     frame_count;
   logic [capture_pkg::buf_aw-1:0]      wptr;
   capture_pkg::ram_req_t               wr_req;
   capture_pkg::ram_req_t               rd_req;
   capture_pkg::ram_req_t               ram_req;
   logic                                rd_grant;
   logic                                rd_valid;
   logic [capture_pkg::axil_data_w-1:0] rd_data;
   logic [capture_pkg::axil_data_w-1:0] ram_rdata;

   serializer_multichannel #(
      .n_chan (n_chan),
      .dw     (dw),
      .l_to_r (l_to_r)
   ) u_serializer (
      .clk        (clk),
      .rst_n      (rst_n),
      .sample_in  (sample_in),
      .data_in    (data_in),
      .gate_out   (gate),
      .stream_out (stream)
   );

   stream_writer #(
      .dw (dw)
   ) u_writer (
      .clk         (clk),
      .rst_n       (rst_n),
      .capture_en  (capture_en),
      .gate        (gate),
      .stream      (stream),
      .wr_req      (wr_req),
      .frame_count (frame_count),
      .wptr        (wptr)
   );

   buffer_arbiter u_arbiter (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_req    (wr_req),
      .rd_req    (rd_req),
      .ram_rdata (ram_rdata),
      .ram_req   (ram_req),
      .rd_grant  (rd_grant),
      .rd_data   (rd_data),
      .rd_valid  (rd_valid)
   );

   sample_ram u_ram (
      .clk     (clk),
      .ram_req (ram_req),
      .rdata   (ram_rdata)
   );

   axil_readout u_axil (
      .clk         (clk),
      .rst_n       (rst_n),
      .axil_req    (axil_req),
      .axil_rsp    (axil_rsp),
      .capture_en  (capture_en),
      .rd_req      (rd_req),
      .rd_grant    (rd_grant),
      .rd_data     (rd_data),
      .rd_valid    (rd_valid),
      .frame_count (frame_count),
      .wptr        (wptr)
   );

endmodule

`default_nettype wire

//--- design/sample_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sample_ram (
   input  logic                                clk,
   input  capture_pkg::ram_req_t               ram_req,
   output logic [capture_pkg::axil_data_w-1:0] rdata    // Valid one cycle after en
);

   localparam int depth = 1 << capture_pkg::buf_aw;

   logic [capture_pkg::axil_data_w-1:0] mem [depth];

   always_ff @(posedge clk) begin
      if (ram_req.en) begin
         if (ram_req.we) begin
            mem[ram_req.addr] <= ram_req.wdata;
         end
         rdata <= mem[ram_req.addr];                  // Old contents on a write
      end
   end

endmodule

`default_nettype wire

//--- design/serialize.sv
`timescale 1ns/1ps
`default_nettype none

module serialize #(
   parameter int dwi = 16                            // Channel word width
) (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           samp,                      // Load strobe, shared by the chain
   input  logic [dwi-1:0] data_in,                   // This cell's channel word
   input  logic [dwi-1:0] stream_in,                 // Word from the upstream cell
   input  logic           gate_in,                   // Gate from the upstream cell
   output logic [dwi-1:0] stream_out,
   output logic           gate_out
);

   // Gate is control state and comes out of reset low
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gate_out <= 1'b0;
      end else begin
         gate_out <= samp ? 1'b1 : gate_in;           // Load marks the word valid
      end
   end

   // Data word only matters while its gate is high
   always_ff @(posedge clk) begin
      if (samp) begin
         stream_out <= data_in;                       // Capture on strobe
      end else begin
         stream_out <= stream_in;                     // Otherwise shift one cell down
      end
   end

endmodule

`default_nettype wire

//--- design/serializer_multichannel.sv
`timescale 1ns/1ps
`default_nettype none

module serializer_multichannel #(
   parameter int n_chan = 8,                         // Channels per frame
   parameter int dw     = 16,                        // Channel word width
   parameter int l_to_r = 1                          // 1 sends CH0 first, 0 the last channel first
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 sample_in,           // One-cycle sample strobe
   input  logic [n_chan*dw-1:0] data_in,             // Flattened channel words, CH0 at the bottom
   output logic                 gate_out,            // High while stream_out carries a word
   output logic [dw-1:0]        stream_out
);

   // Element 0 is the output end, element n_chan the far end
   logic [dw-1:0] chain_d [n_chan+1];
   logic          chain_g [n_chan+1];

   assign chain_d[n_chan] = '0;                       // Far end shifts in zero
   assign chain_g[n_chan] = 1'b0;                     // with the gate low

   for (genvar i = 0; i < n_chan; i++) begin : g_cell
      // Cell i leaves the chain i cycles after the sample
      localparam int src = (l_to_r != 0) ? i : n_chan - 1 - i;

      serialize #(
         .dwi (dw)
      ) u_serialize (
         .clk        (clk),
         .rst_n      (rst_n),
         .samp       (sample_in),
         .data_in    (data_in[src*dw +: dw]),
         .stream_in  (chain_d[i+1]),
         .gate_in    (chain_g[i+1]),
         .stream_out (chain_d[i]),
         .gate_out   (chain_g[i])
      );
   end

   assign stream_out = chain_d[0];
   assign gate_out   = chain_g[0];

   // A frame is n_chan words long; only a new sample may extend the gate
   a_gate_len : assert property (@(posedge clk) disable iff (!rst_n)
      not ((gate_out && !sample_in) [*n_chan+1]));

endmodule

`default_nettype wire

//--- design/stream_writer.sv
`timescale 1ns/1ps
`default_nettype none

module stream_writer #(
   parameter int dw = 16                             // Stream word width, at most 32
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                capture_en, // From the control register
   input  logic                                gate,
   input  logic [dw-1:0]                       stream,
   output capture_pkg::ram_req_t               wr_req,     // To the arbiter, always wins
   output logic [capture_pkg::frame_w-1:0]     frame_count,
   output logic [capture_pkg::buf_aw-1:0]      wptr
);

   logic gate_q;                                      // Gate one cycle back
   logic wr_fire;                                     // Word stored this cycle
   logic frame_end;                                   // Falling edge of the gate

   assign wr_fire   = gate && capture_en;
   assign frame_end = gate_q && !gate;

   // Request goes out in the gated cycle itself, RAM writes on the next edge
   always_comb begin
      wr_req              = '0;
      wr_req.en           = wr_fire;
      wr_req.we           = wr_fire;
      wr_req.addr         = wptr;
      wr_req.wdata[dw-1:0] = stream;                  // Upper bits stay zero
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gate_q      <= 1'b0;
         wptr        <= '0;
         frame_count <= '0;
      end else begin
         gate_q <= gate;
         if (wr_fire) begin
            wptr <= wptr + 1'b1;                      // Wraps at buffer depth
         end
         if (frame_end && capture_en) begin
            frame_count <= frame_count + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- tests/tb_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_capture_top;

   localparam int n_chan  = 8;
   localparam int dw      = 16;
   localparam int l_to_r  = 1;
   localparam int depth   = 1 << capture_pkg::buf_aw;   // Buffer words
   localparam int t_limit = 100;                        // Cycles allowed per wait

   typedef struct packed {
      logic [1:0]                          resp;
      logic [capture_pkg::axil_data_w-1:0] data;
   } rd_exp_t;                                          // One expected read response

   logic                   clk;
   logic                   rst_n;
   logic                   sample_in;
   logic [n_chan*dw-1:0]   data_in;
   capture_pkg::axil_req_t axil_req;
   capture_pkg::axil_rsp_t axil_rsp;

   logic [31:0]            rng_state;
   logic [n_chan*dw-1:0]   frame_q [$];                 // Captured frames, oldest first
   rd_exp_t                exp_q [$];                   // Expected read responses in order

   capture_top #(
      .n_chan (n_chan),
      .dw     (dw),
      .l_to_r (l_to_r)
   ) u_capture_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .sample_in (sample_in),
      .data_in   (data_in),
      .axil_req  (axil_req),
      .axil_rsp  (axil_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;                           // 40 ns period
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);        // xorshift32
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Word c of frame f lands here
   function automatic int buffer_index(input int f, input int c);
      return (f * n_chan + c) % depth;
   endfunction

   // Reference model of the c-th word of frame f as stored and zero-extended
   function automatic logic [31:0] expected_word(input int f, input int c);
      int          ch;
      logic [31:0] w;
      ch          = (l_to_r != 0) ? c : n_chan - 1 - c; // Stream order to channel
      w           = '0;
      w[dw-1:0]   = frame_q[f][ch*dw +: dw];
      return w;
   endfunction

   // Latest word written at buffer index idx
   function automatic logic [31:0] newest_word(input int idx);
      int total;
      int g;
      total = frame_q.size() * n_chan;
      g     = ((total - 1 - idx) / depth) * depth + idx;
      return expected_word(g / n_chan, g % n_chan);
   endfunction

   function automatic logic [11:0] window_addr(input int idx);
      return capture_pkg::buf_base + 12'(4 * idx);
   endfunction

   task automatic report_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("MISMATCH %s got 0x%08h expected 0x%08h", sig, got, exp);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic abort_run(input string what);
      $display("ERROR %s", what);
      $display("Simulation failed");
      $fatal(1);
   endtask

   // Sends one frame of random words with strobes n_chan+4 cycles apart
   task automatic send_frame(input bit keep);
      logic [n_chan*dw-1:0] d;
      for (int i = 0; i < n_chan * dw / 32; i++) begin
         d[i*32 +: 32] = next_rand();
      end
      @(posedge clk);
      #2;
      sample_in = 1'b1;
      data_in   = d;
      if (keep) frame_q.push_back(d);                   // Only frames seen with capture on
      @(posedge clk);
      #2;
      sample_in = 1'b0;
      repeat (n_chan + 2) @(posedge clk);
   endtask

   task automatic write_host(input logic [11:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
      int n;
      @(posedge clk);
      #2;
      axil_req.awvalid = 1'b1;                          // Address and data together
      axil_req.awaddr  = addr;
      axil_req.wvalid  = 1'b1;
      axil_req.wdata   = data;
      axil_req.wstrb   = '1;
      axil_req.bready  = 1'b1;
      n = 0;
      @(negedge clk);
      while (!axil_rsp.awready) begin
         n++;
         if (n > t_limit) abort_run("timed out waiting for awready");
         @(negedge clk);
      end
      assert (axil_rsp.wready) else abort_run("wready low in the cycle awready was high");
      @(posedge clk);
      #2;
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      n = 0;
      @(negedge clk);
      while (!axil_rsp.bvalid) begin
         n++;
         if (n > t_limit) abort_run("timed out waiting for bvalid");
         @(negedge clk);
      end
      assert (axil_rsp.bresp == exp_resp)
         else report_mismatch("bresp", axil_rsp.bresp, exp_resp);
      @(posedge clk);
      #2;
      axil_req.bready = 1'b0;
   endtask

   // Drives one read and queues its expected beat for the compare process
   task automatic read_host(input logic [11:0] addr, input int hold,
                            input logic [31:0] exp_data, input logic [1:0] exp_resp);
      rd_exp_t     e;
      logic [31:0] held;
      int          n;
      e.resp = exp_resp;
      e.data = exp_data;
      exp_q.push_back(e);
      @(posedge clk);
      #2;
      axil_req.arvalid = 1'b1;
      axil_req.araddr  = addr;
      axil_req.rready  = (hold == 0);                   // Back-pressure when hold is set
      n = 0;
      @(negedge clk);
      while (!axil_rsp.arready) begin
         n++;
         if (n > t_limit) abort_run("timed out waiting for arready");
         @(negedge clk);
      end
      @(posedge clk);
      #2;
      axil_req.arvalid = 1'b0;
      n = 0;
      @(negedge clk);
      while (!axil_rsp.rvalid) begin
         n++;
         if (n > t_limit) abort_run("timed out waiting for rvalid");
         @(negedge clk);
      end
      if (hold > 0) begin
         held = axil_rsp.rdata;
         repeat (hold) begin
            @(negedge clk);
            assert (axil_rsp.rvalid) else abort_run("rvalid dropped while rready was low");
            assert (axil_rsp.rdata == held)
               else report_mismatch("rdata", axil_rsp.rdata, held);
         end
         @(posedge clk);
         #2;
         axil_req.rready = 1'b1;
         @(negedge clk);
      end
      @(posedge clk);
      #2;
      axil_req.rready = 1'b0;
   endtask

   // Compare each accepted read beat with the queued expectation
   always @(negedge clk) begin
      rd_exp_t e;
      if (rst_n && axil_rsp.rvalid && axil_req.rready) begin
         assert (exp_q.size() > 0) else abort_run("read response with no read outstanding");
         e = exp_q.pop_front();
         assert (axil_rsp.rdata == e.data)
            else report_mismatch("rdata", axil_rsp.rdata, e.data);
         assert (axil_rsp.rresp == e.resp)
            else report_mismatch("rresp", axil_rsp.rresp, e.resp);
      end
   end

   initial begin
      int n;
      int f0;
      int base;
      rng_state = 32'd83366;
      rst_n     = 1'b0;
      sample_in = 1'b0;
      data_in   = '0;
      axil_req  = '0;
      repeat (4) @(posedge clk);
      #2;
      rst_n = 1'b1;
      assert (!axil_rsp.bvalid && !axil_rsp.rvalid)
         else abort_run("response valid high out of reset");

      read_host(capture_pkg::reg_ctrl, 0, 32'h0, 2'b00);   // Reset values
      read_host(capture_pkg::reg_frames, 0, 32'h0, 2'b00);
      read_host(capture_pkg::reg_wptr, 0, 32'h0, 2'b00);
      repeat (3) send_frame(1'b0);                         // Capture still off
      read_host(capture_pkg::reg_wptr, 0, 32'h0, 2'b00);
      read_host(capture_pkg::reg_frames, 0, 32'h0, 2'b00);

      write_host(capture_pkg::reg_ctrl, 32'h1, 2'b00);
      read_host(capture_pkg::reg_ctrl, 0, 32'h1, 2'b00);
      repeat (5) send_frame(1'b1);
      read_host(capture_pkg::reg_frames, 0, frame_q.size(), 2'b00);
      read_host(capture_pkg::reg_wptr, 0, (frame_q.size() * n_chan) % depth, 2'b00);
      for (int i = 0; i < frame_q.size() * n_chan; i++) begin
         read_host(window_addr(i), 0, newest_word(i), 2'b00);
      end

      // Past 256 words the pointer wraps over the oldest frames
      repeat (30) send_frame(1'b1);
      read_host(capture_pkg::reg_frames, 0, frame_q.size(), 2'b00);
      read_host(capture_pkg::reg_wptr, 0, (frame_q.size() * n_chan) % depth, 2'b00);
      for (int i = 0; i < depth; i++) begin
         read_host(window_addr(i), 0, newest_word(i), 2'b00);
      end

      // Host reads compete with a live stream
      base = frame_q.size();
      fork
         repeat (12) send_frame(1'b1);
         begin
            n = 0;
            while (frame_q.size() <= base) begin
               n++;
               if (n > t_limit) abort_run("timed out waiting for the stream to start");
               @(posedge clk);
            end
            for (int r = 0; r < 10; r++) begin
               f0 = frame_q.size() - 2;                    // Fully written, not yet overwritten
               read_host(window_addr(buffer_index(f0, r % n_chan)), (r % 3 == 1) ? 4 : 0,
                         expected_word(f0, r % n_chan), 2'b00);
            end
         end
      join
      read_host(capture_pkg::reg_frames, 0, frame_q.size(), 2'b00);
      read_host(capture_pkg::reg_wptr, 0, (frame_q.size() * n_chan) % depth, 2'b00);

      // No stream word was lost to a competing host read
      for (int i = 0; i < depth; i++) begin
         read_host(window_addr(i), 0, newest_word(i), 2'b00);
      end

      read_host(12'h100, 0, 32'h0, 2'b10);                 // Unmapped gives SLVERR
      read_host(12'h00C, 2, 32'h0, 2'b10);

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
design/capture_pkg.sv
design/serialize.sv
design/serializer_multichannel.sv
design/stream_writer.sv
design/buffer_arbiter.sv
design/sample_ram.sv
design/axil_readout.sv
design/capture_top.sv
tests/tb_capture_top.sv
